// ==== memory_hierarchy_testdata.txt ====
// port (a instr, b data, d memory after run), op (0 rd, 1 wr, +2 with next line)
// then address, write data, byte mask, expected word
a 0 00001000 00000000 0 00001000
a 0 00001004 00000000 0 00001004
a 0 0000101c 00000000 0 0000101c
a 0 00001020 00000000 0 00001020
a 0 00001008 00000000 0 00001008
b 1 00002000 aabbccdd 3 00000000
b 0 00002000 00000000 0 0000ccdd
b 1 00002004 11223344 c 00000000
b 0 00002004 00000000 0 11222004
b 1 00002008 deadbeef f 00000000
b 1 00002008 00000055 1 00000000
b 0 00002008 00000000 0 deadbe55
b 0 00002010 00000000 0 00002010
b 0 00002100 00000000 0 00002100
b 1 00002104 12345678 f 00000000
b 0 00002000 00000000 0 0000ccdd
b 0 00002104 00000000 0 12345678
b 1 00002204 5566abcd 6 00000000
b 0 00002204 00000000 0 0066ab04
b 0 00002008 00000000 0 deadbe55
b 0 00002204 00000000 0 0066ab04
a 2 00001044 00000000 0 00001044
b 0 00002048 00000000 0 00002048
a 2 00001000 00000000 0 00001000
b 1 0000204c cafef00d f 00000000
b 2 0000204c 00000000 0 cafef00d
a 0 00001064 00000000 0 00001064
a 2 00001080 00000000 0 00001080
b 0 00002140 00000000 0 00002140
b 0 0000204c 00000000 0 cafef00d
b 3 00002250 a1b2c3d4 9 00000000
a 0 000010a0 00000000 0 000010a0
b 0 00002250 00000000 0 a10022d4
d 0 00002000 00000000 0 0000ccdd
d 0 00002004 00000000 0 11222004
d 0 00002008 00000000 0 deadbe55
d 0 00002104 00000000 0 12345678
d 0 00002204 00000000 0 0066ab04
d 0 0000204c 00000000 0 cafef00d

// ==== build.f ====
mem_pkg.sv
icache.sv
dcache.sv
cache_arbiter.sv
eviction_write_buffer.sv
memory_hierarchy.sv
memory_hierarchy_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps
TOP = memory_hierarchy_tb
FILELIST = build.f
OBJDIR = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJDIR)

// ==== memory_hierarchy_tb.sv ====
module memory_hierarchy_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_entries = 64;
	localparam int reset_cycles = 16;

	logic clk = 1'b0;
	logic rst;
	logic read_a;
	mem_pkg::addr_t address_a;
	mem_pkg::word_t rdata_a;
	logic resp_a;
	logic read_b;
	logic write_b;
	mem_pkg::addr_t address_b;
	mem_pkg::word_t wdata_b;
	mem_pkg::mask_t wmask_b;
	mem_pkg::word_t rdata_b;
	logic resp_b;
	logic read;
	logic write;
	mem_pkg::addr_t address;
	mem_pkg::line_t wdata;
	mem_pkg::line_t rdata;
	logic resp;

	// six words per entry in the order of the file columns
	logic [31:0] entries [max_entries * 6];
	int num_entries;
	int cycles = 0;
	int cycle_limit = 1000000;
	int checks = 0;
	int value_errors = 0;
	int protocol_errors = 0;
	logic mem_busy;
	// sparse physical memory keyed by line address
	mem_pkg::line_t mem_lines [mem_pkg::addr_t];

	memory_hierarchy DUT (.*);

	always #2 clk = ~clk;

	// line contents as memory holds them now
	function automatic mem_pkg::line_t line_at(input mem_pkg::addr_t line_addr);
		mem_pkg::line_t result;
		if (mem_lines.exists(line_addr)) begin
			result = mem_lines[line_addr];
		end else begin
			// every word holds its own byte address
			for (int w = 0; w < 8; w++) begin
				result[w * 32 +: 32] = line_addr + 32'(w * 4);
			end
		end
		return result;
	endfunction

	task automatic report_counts();
		$display("checks %0d, value errors %0d, protocol errors %0d",
			checks, value_errors, protocol_errors);
	endtask

	// memory model answers one request at a time after 1 to 4 cycles
	initial begin
		int delay;
		logic is_write;
		mem_pkg::addr_t line_addr;
		mem_pkg::line_t line_data;
		void'($urandom(32'h8ec8));
		resp = 1'b0;
		rdata = '0;
		mem_busy = 1'b0;
		forever begin
			@(negedge clk);
			if (!rst && (read || write)) begin
				mem_busy = 1'b1;
				is_write = write;
				line_addr = {address[31:5], 5'b0};
				line_data = wdata;
				delay = $urandom_range(1, 4);
				repeat (delay) @(posedge clk);
				#0.5;
				if (is_write) begin
					mem_lines[line_addr] = line_data;
				end else begin
					rdata = line_at(line_addr);
				end
				resp = 1'b1;
				@(posedge clk);
				#0.5;
				resp = 1'b0;
				mem_busy = 1'b0;
			end
		end
	end

	// a port may see resp only while it holds a request
	always @(negedge clk) begin
		assert (!resp_a || read_a) else begin
			protocol_errors++;
			$display("resp on port a at cycle %0d with no request outstanding", cycles);
		end
		assert (!resp_b || read_b || write_b) else begin
			protocol_errors++;
			$display("resp on port b at cycle %0d with no request outstanding", cycles);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("run timed out after %0d cycles, accesses did not complete", cycles);
			report_counts();
			$display("** FAIL **");
			$finish;
		end
	end

	// instruction fetch on port a
	task automatic access_a(input int idx);
		string name;
		mem_pkg::word_t expected;
		name = $sformatf("entry%0d_a_read", idx);
		expected = entries[idx * 6 + 5];
		@(posedge clk);
		#0.5;
		read_a = 1'b1;
		address_a = entries[idx * 6 + 2];
		@(negedge clk);
		while (!resp_a) begin
			@(negedge clk);
		end
		checks++;
		assert (rdata_a === expected) else begin
			value_errors++;
			$display("ERR %s expected %h actual %h", name, expected, rdata_a);
		end
		// request held through the resp cycle and dropped after it
		@(posedge clk);
		#0.5;
		read_a = 1'b0;
	endtask

	// load or store on port b with a compare for loads
	task automatic access_b(input int idx);
		string name;
		logic is_write;
		mem_pkg::word_t expected;
		is_write = entries[idx * 6 + 1][0];
		expected = entries[idx * 6 + 5];
		name = $sformatf("entry%0d_b_%s", idx, is_write ? "write" : "read");
		@(posedge clk);
		#0.5;
		read_b = !is_write;
		write_b = is_write;
		address_b = entries[idx * 6 + 2];
		wdata_b = entries[idx * 6 + 3];
		wmask_b = entries[idx * 6 + 4][3:0];
		@(negedge clk);
		while (!resp_b) begin
			@(negedge clk);
		end
		if (!is_write) begin
			checks++;
			assert (rdata_b === expected) else begin
				value_errors++;
				$display("ERR %s expected %h actual %h", name, expected, rdata_b);
			end
		end
		@(posedge clk);
		#0.5;
		read_b = 1'b0;
		write_b = 1'b0;
	endtask

	// port d lines are memory checks for the end of the run
	task automatic run_entry(input int idx);
		if (entries[idx * 6] == 32'ha) begin
			access_a(idx);
		end else if (entries[idx * 6] == 32'hb) begin
			access_b(idx);
		end
	endtask

	// no lower level traffic for a few cycles, so the buffer has drained
	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < 8) begin
			@(negedge clk);
			if (read || write || mem_busy) begin
				quiet = 0;
			end else begin
				quiet++;
			end
		end
	endtask

	// evicted words must have reached memory
	task automatic check_memory();
		mem_pkg::addr_t addr;
		mem_pkg::line_t line;
		mem_pkg::word_t actual;
		for (int i = 0; i < num_entries; i++) begin
			if (entries[i * 6] == 32'hd) begin
				addr = entries[i * 6 + 2];
				line = line_at({addr[31:5], 5'b0});
				actual = line[addr[4:2] * 32 +: 32];
				checks++;
				assert (actual === entries[i * 6 + 5]) else begin
					value_errors++;
					$display("ERR entry%0d_d_memory expected %h actual %h",
						i, entries[i * 6 + 5], actual);
				end
			end
		end
	endtask

	initial begin
		int idx;
		rst = 1'b1;
		read_a = 1'b0;
		address_a = '0;
		read_b = 1'b0;
		write_b = 1'b0;
		address_b = '0;
		wdata_b = '0;
		wmask_b = '0;
		for (int i = 0; i < max_entries * 6; i++) begin
			entries[i] = '0;
		end
		$readmemh("memory_hierarchy_testdata.txt", entries);
		// list ends at the first entry without a port
		num_entries = 0;
		while (num_entries < max_entries && entries[num_entries * 6] != '0) begin
			num_entries++;
		end
		cycle_limit = 200 * num_entries + reset_cycles;
		repeat (reset_cycles) @(posedge clk);
		#0.5;
		rst = 1'b0;
		idx = 0;
		while (idx < num_entries) begin
			// op bit 1 starts this access in the same cycle as the next one
			if (entries[idx * 6 + 1][1] && idx + 1 < num_entries) begin
				fork
					run_entry(idx);
					run_entry(idx + 1);
				join
				idx += 2;
			end else begin
				run_entry(idx);
				idx++;
			end
		end
		wait_quiet();
		check_memory();
		report_counts();
		if (value_errors + protocol_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule : memory_hierarchy_tb

// ==== memory_hierarchy.sv ====
module memory_hierarchy (
	input logic clk,
	input logic rst,
	// port a, instruction fetch
	input logic read_a,
	input mem_pkg::addr_t address_a,
	output mem_pkg::word_t rdata_a,
	output logic resp_a,
	// port b, loads and stores
	input logic read_b,
	input logic write_b,
	input mem_pkg::addr_t address_b,
	input mem_pkg::word_t wdata_b,
	input mem_pkg::mask_t wmask_b,
	output mem_pkg::word_t rdata_b,
	output logic resp_b,
	// physical memory
	output logic read,
	output logic write,
	output mem_pkg::addr_t address,
	output mem_pkg::line_t wdata,
	input mem_pkg::line_t rdata,
	input logic resp
);

	// icache to arbiter
	logic read_i;
	mem_pkg::addr_t address_i;
	mem_pkg::line_t rdata_i;
	logic resp_i;

	// dcache to arbiter
	logic read_d;
	logic write_d;
	mem_pkg::addr_t address_d;
	mem_pkg::line_t wdata_d;
	mem_pkg::line_t rdata_d;
	logic resp_d;

	// arbiter to eviction buffer
	logic read_l2;
	logic write_l2;
	mem_pkg::addr_t address_l2;
	mem_pkg::line_t wdata_l2;
	mem_pkg::line_t rdata_l2;
	logic resp_l2;

	icache instruction_cache (
		.clk,
		.rst,
		.mem_read(read_a),
		.mem_address(address_a),
		.mem_rdata(rdata_a),
		.mem_resp(resp_a),
		.pmem_read(read_i),
		.pmem_address(address_i),
		.pmem_rdata(rdata_i),
		.pmem_resp(resp_i)
	);

	dcache data_cache (
		.clk,
		.rst,
		.mem_read(read_b),
		.mem_write(write_b),
		.mem_address(address_b),
		.mem_wdata(wdata_b),
		.mem_byte_enable(wmask_b),
		.mem_rdata(rdata_b),
		.mem_resp(resp_b),
		.pmem_read(read_d),
		.pmem_write(write_d),
		.pmem_address(address_d),
		.pmem_wdata(wdata_d),
		.pmem_rdata(rdata_d),
		.pmem_resp(resp_d)
	);

	cache_arbiter arbiter (
		.clk,
		.rst,
		.icache_read(read_i),
		.icache_address(address_i),
		.icache_rdata(rdata_i),
		.icache_resp(resp_i),
		.dcache_read(read_d),
		.dcache_write(write_d),
		.dcache_address(address_d),
		.dcache_wdata(wdata_d),
		.dcache_rdata(rdata_d),
		.dcache_resp(resp_d),
		.l2_read(read_l2),
		.l2_write(write_l2),
		.l2_address(address_l2),
		.l2_wdata(wdata_l2),
		.l2_rdata(rdata_l2),
		.l2_resp(resp_l2)
	);

	// last stage before physical memory
	eviction_write_buffer eviction_write_buffer_l2 (
		.clk,
		.rst,
		.read(read_l2),
		.write(write_l2),
		.address(address_l2),
		.wdata(wdata_l2),
		.rdata(rdata_l2),
		.resp(resp_l2),
		.pmem_read(read),
		.pmem_write(write),
		.pmem_address(address),
		.pmem_wdata(wdata),
		.pmem_rdata(rdata),
		.pmem_resp(resp)
	);

endmodule : memory_hierarchy

// ==== eviction_write_buffer.sv ====
module eviction_write_buffer (
	input logic clk,
	input logic rst,
	input logic read,
	input logic write,
	input mem_pkg::addr_t address,
	input mem_pkg::line_t wdata,
	output mem_pkg::line_t rdata,
	output logic resp,
	output logic pmem_read,
	output logic pmem_write,
	output mem_pkg::addr_t pmem_address,
	output mem_pkg::line_t pmem_wdata,
	input mem_pkg::line_t pmem_rdata,
	input logic pmem_resp
);

	mem_pkg::ewb_state_t state;
	// the one held dirty line
	mem_pkg::addr_t buf_address;
	mem_pkg::line_t buf_data;

	logic held;
	logic match;
	logic buf_hit;
	logic accept;
	logic issue;
	logic drain_start;

	assign held = (state != mem_pkg::ewb_empty);
	// compare line addresses only
	assign match = held &&
		(address[31:mem_pkg::offset_bits] == buf_address[31:mem_pkg::offset_bits]);
	assign buf_hit = read && match && !resp;
	// empty and no memory read in flight
	assign accept = (state == mem_pkg::ewb_empty) && write && !resp && !pmem_read;
	assign issue = (state == mem_pkg::ewb_empty) && !write && read && !resp && !pmem_read;
	assign drain_start = (state == mem_pkg::ewb_full) && !buf_hit;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_pkg::ewb_empty;
			resp <= 1'b0;
			pmem_read <= 1'b0;
			pmem_write <= 1'b0;
		end else begin
			resp <= 1'b0;
			case (state)
				mem_pkg::ewb_empty: begin
					if (pmem_read) begin
						if (pmem_resp) begin
							pmem_read <= 1'b0;
							resp <= 1'b1;
						end
					end else if (accept) begin
						// ack now, drain later
						resp <= 1'b1;
						state <= mem_pkg::ewb_full;
					end else if (issue) begin
						pmem_read <= 1'b1;
					end
				end
				mem_pkg::ewb_full: begin
					if (buf_hit) begin
						resp <= 1'b1;
					end else begin
						pmem_write <= 1'b1;
						state <= mem_pkg::ewb_drain;
					end
				end
				mem_pkg::ewb_drain: begin
					// line still held, so matching reads are served
					if (buf_hit) begin
						resp <= 1'b1;
					end
					if (pmem_resp) begin
						pmem_write <= 1'b0;
						state <= mem_pkg::ewb_empty;
					end
				end
				default: state <= mem_pkg::ewb_empty;
			endcase
		end
	end

	// held line, memory request and returned line
	always_ff @(posedge clk) begin
		if (accept) begin
			buf_address <= address;
			buf_data <= wdata;
		end
		if (drain_start) begin
			pmem_address <= buf_address;
			pmem_wdata <= buf_data;
		end
		if (issue) begin
			pmem_address <= address;
		end
		if (buf_hit) begin
			rdata <= buf_data;
		end else if (pmem_read && pmem_resp) begin
			rdata <= pmem_rdata;
		end
	end

endmodule : eviction_write_buffer

// ==== cache_arbiter.sv ====
module cache_arbiter (
	input logic clk,
	input logic rst,
	input logic icache_read,
	input mem_pkg::addr_t icache_address,
	output mem_pkg::line_t icache_rdata,
	output logic icache_resp,
	input logic dcache_read,
	input logic dcache_write,
	input mem_pkg::addr_t dcache_address,
	input mem_pkg::line_t dcache_wdata,
	output mem_pkg::line_t dcache_rdata,
	output logic dcache_resp,
	output logic l2_read,
	output logic l2_write,
	output mem_pkg::addr_t l2_address,
	output mem_pkg::line_t l2_wdata,
	input mem_pkg::line_t l2_rdata,
	input logic l2_resp
);

	mem_pkg::arb_state_t state;
	// returning line, shared by both clients
	mem_pkg::line_t rdata_q;
	logic d_req;

	assign d_req = dcache_read || dcache_write;
	assign icache_rdata = rdata_q;
	assign dcache_rdata = rdata_q;

	// grant and handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_pkg::arb_idle;
			icache_resp <= 1'b0;
			dcache_resp <= 1'b0;
			l2_read <= 1'b0;
			l2_write <= 1'b0;
		end else begin
			case (state)
				mem_pkg::arb_idle: begin
					// dcache has priority
					if (d_req) begin
						l2_read <= dcache_read;
						l2_write <= dcache_write;
						state <= mem_pkg::arb_serve_d;
					end else if (icache_read) begin
						l2_read <= 1'b1;
						state <= mem_pkg::arb_serve_i;
					end
				end
				mem_pkg::arb_serve_i: begin
					// back to idle one cycle after the forwarded resp
					if (icache_resp) begin
						icache_resp <= 1'b0;
						state <= mem_pkg::arb_idle;
					end else if (l2_resp) begin
						l2_read <= 1'b0;
						icache_resp <= 1'b1;
					end
				end
				mem_pkg::arb_serve_d: begin
					if (dcache_resp) begin
						dcache_resp <= 1'b0;
						state <= mem_pkg::arb_idle;
					end else if (l2_resp) begin
						l2_read <= 1'b0;
						l2_write <= 1'b0;
						dcache_resp <= 1'b1;
					end
				end
				default: state <= mem_pkg::arb_idle;
			endcase
		end
	end

	// registered request and response payload
	always_ff @(posedge clk) begin
		if (state == mem_pkg::arb_idle) begin
			if (d_req) begin
				l2_address <= dcache_address;
				l2_wdata <= dcache_wdata;
			end else begin
				l2_address <= icache_address;
			end
		end
		if (l2_resp) begin
			rdata_q <= l2_rdata;
		end
	end

endmodule : cache_arbiter

// ==== dcache.sv ====
module dcache (
	input logic clk,
	input logic rst,
	input logic mem_read,
	input logic mem_write,
	input mem_pkg::addr_t mem_address,
	input mem_pkg::word_t mem_wdata,
	input mem_pkg::mask_t mem_byte_enable,
	output mem_pkg::word_t mem_rdata,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output mem_pkg::addr_t pmem_address,
	output mem_pkg::line_t pmem_wdata,
	input mem_pkg::line_t pmem_rdata,
	input logic pmem_resp
);

	// address fields
	mem_pkg::tag_t tag;
	mem_pkg::set_t set;
	logic [mem_pkg::word_bits-1:0] word_idx;
	mem_pkg::addr_t line_address;

	// storage with per set dirty bit
	mem_pkg::line_t data_array [mem_pkg::num_sets];
	mem_pkg::tag_t tag_array [mem_pkg::num_sets];
	logic [mem_pkg::num_sets-1:0] valid;
	logic [mem_pkg::num_sets-1:0] dirty;

	mem_pkg::dcache_state_t state;
	logic lookup;
	logic hit;
	logic victim_dirty;
	logic fill_done;
	mem_pkg::line_t hit_line;
	mem_pkg::line_t fill_line;

	// replace the enabled bytes of one word in a line
	function automatic mem_pkg::line_t merge_word(
		input mem_pkg::line_t line,
		input mem_pkg::word_t wdata,
		input mem_pkg::mask_t mask,
		input logic [mem_pkg::word_bits-1:0] idx
	);
		mem_pkg::line_t merged;
		merged = line;
		for (int b = 0; b < 4; b++) begin
			if (mask[b]) begin
				merged[idx * 32 + b * 8 +: 8] = wdata[b * 8 +: 8];
			end
		end
		return merged;
	endfunction

	assign tag = mem_address[31 -: mem_pkg::tag_bits];
	assign set = mem_address[mem_pkg::offset_bits +: mem_pkg::set_bits];
	assign word_idx = mem_address[mem_pkg::offset_bits-1:2];
	assign line_address = {mem_address[31:mem_pkg::offset_bits], {mem_pkg::offset_bits{1'b0}}};

	assign lookup = (state == mem_pkg::d_idle) && (mem_read || mem_write) && !mem_resp;
	assign hit = valid[set] && (tag_array[set] == tag);
	assign victim_dirty = valid[set] && dirty[set];
	assign fill_done = (state == mem_pkg::d_fill) && pmem_resp;

	// write hit merges into the stored line
	assign hit_line = merge_word(data_array[set], mem_wdata, mem_byte_enable, word_idx);
	// write miss is allocated first, then merged
	assign fill_line = mem_write ?
		merge_word(pmem_rdata, mem_wdata, mem_byte_enable, word_idx) : pmem_rdata;

	// control path
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_pkg::d_idle;
			mem_resp <= 1'b0;
			pmem_read <= 1'b0;
			pmem_write <= 1'b0;
			valid <= '0;
			dirty <= '0;
		end else begin
			mem_resp <= 1'b0;
			case (state)
				mem_pkg::d_idle: begin
					if (lookup) begin
						if (hit) begin
							mem_resp <= 1'b1;
							if (mem_write) begin
								dirty[set] <= 1'b1;
							end
						end else if (victim_dirty) begin
							// victim goes out before the fill
							pmem_write <= 1'b1;
							state <= mem_pkg::d_write_back;
						end else begin
							pmem_read <= 1'b1;
							state <= mem_pkg::d_fill;
						end
					end
				end
				mem_pkg::d_write_back: begin
					if (pmem_resp) begin
						pmem_write <= 1'b0;
						pmem_read <= 1'b1;
						state <= mem_pkg::d_fill;
					end
				end
				mem_pkg::d_fill: begin
					if (pmem_resp) begin
						pmem_read <= 1'b0;
						valid[set] <= 1'b1;
						// allocated write leaves the line dirty
						dirty[set] <= mem_write;
						mem_resp <= 1'b1;
						state <= mem_pkg::d_idle;
					end
				end
				default: state <= mem_pkg::d_idle;
			endcase
		end
	end

	// arrays, returned word, lower level address and line
	always_ff @(posedge clk) begin
		if (lookup) begin
			mem_rdata <= data_array[set][word_idx * 32 +: 32];
			if (hit && mem_write) begin
				data_array[set] <= hit_line;
			end
			if (victim_dirty) begin
				// victim's own address, rebuilt from its tag
				pmem_address <= {tag_array[set], set, {mem_pkg::offset_bits{1'b0}}};
				pmem_wdata <= data_array[set];
			end else begin
				pmem_address <= line_address;
			end
		end
		// switch to the fill address once the victim is out
		if ((state == mem_pkg::d_write_back) && pmem_resp) begin
			pmem_address <= line_address;
		end
		if (fill_done) begin
			data_array[set] <= fill_line;
			tag_array[set] <= tag;
			mem_rdata <= pmem_rdata[word_idx * 32 +: 32];
		end
	end

endmodule : dcache

// ==== icache.sv ====
module icache (
	input logic clk,
	input logic rst,
	input logic mem_read,
	input mem_pkg::addr_t mem_address,
	output mem_pkg::word_t mem_rdata,
	output logic mem_resp,
	output logic pmem_read,
	output mem_pkg::addr_t pmem_address,
	input mem_pkg::line_t pmem_rdata,
	input logic pmem_resp
);

	// address fields
	mem_pkg::tag_t tag;
	mem_pkg::set_t set;
	logic [mem_pkg::word_bits-1:0] word_idx;

	// storage, 8 sets
	mem_pkg::line_t data_array [mem_pkg::num_sets];
	mem_pkg::tag_t tag_array [mem_pkg::num_sets];
	logic [mem_pkg::num_sets-1:0] valid;

	mem_pkg::icache_state_t state;
	logic lookup;
	logic hit;
	logic fill_done;

	assign tag = mem_address[31 -: mem_pkg::tag_bits];
	assign set = mem_address[mem_pkg::offset_bits +: mem_pkg::set_bits];
	assign word_idx = mem_address[mem_pkg::offset_bits-1:2];

	// new request seen in idle, not the one just answered
	assign lookup = (state == mem_pkg::i_idle) && mem_read && !mem_resp;
	assign hit = valid[set] && (tag_array[set] == tag);
	assign fill_done = (state == mem_pkg::i_fill) && pmem_resp;

	// control path
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_pkg::i_idle;
			mem_resp <= 1'b0;
			pmem_read <= 1'b0;
			valid <= '0;
		end else begin
			// resp is a single cycle pulse
			mem_resp <= 1'b0;
			case (state)
				mem_pkg::i_idle: begin
					if (lookup) begin
						if (hit) begin
							mem_resp <= 1'b1;
						end else begin
							pmem_read <= 1'b1;
							state <= mem_pkg::i_fill;
						end
					end
				end
				mem_pkg::i_fill: begin
					if (pmem_resp) begin
						// line arrives, answer straight from it
						pmem_read <= 1'b0;
						valid[set] <= 1'b1;
						mem_resp <= 1'b1;
						state <= mem_pkg::i_idle;
					end
				end
				default: state <= mem_pkg::i_idle;
			endcase
		end
	end

	// arrays and returned word
	always_ff @(posedge clk) begin
		if (lookup) begin
			mem_rdata <= data_array[set][word_idx * 32 +: 32];
			// line aligned miss address
			pmem_address <= {mem_address[31:mem_pkg::offset_bits], {mem_pkg::offset_bits{1'b0}}};
		end
		if (fill_done) begin
			data_array[set] <= pmem_rdata;
			tag_array[set] <= tag;
			mem_rdata <= pmem_rdata[word_idx * 32 +: 32];
		end
	end

endmodule : icache

// ==== mem_pkg.sv ====
package mem_pkg;

	// line geometry
	localparam int set_bits = 3;
	localparam int offset_bits = 5;
	localparam int tag_bits = 32 - set_bits - offset_bits;
	localparam int num_sets = 1 << set_bits;
	// word index inside a line
	localparam int word_bits = offset_bits - 2;

	// plain vectors with a meaning
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0] mask_t;
	typedef logic [255:0] line_t;
	typedef logic [tag_bits-1:0] tag_t;
	typedef logic [set_bits-1:0] set_t;

	// instruction cache fsm
	typedef enum logic {
		i_idle,
		i_fill
	} icache_state_t;

	// data cache fsm
	typedef enum logic [1:0] {
		d_idle,
		d_write_back,
		d_fill
	} dcache_state_t;

	// arbiter fsm
	typedef enum logic [1:0] {
		arb_idle,
		arb_serve_i,
		arb_serve_d
	} arb_state_t;

	// eviction buffer fsm
	typedef enum logic [1:0] {
		ewb_empty,
		ewb_full,
		ewb_drain
	} ewb_state_t;

endpackage : mem_pkg
